// ==== include/exe_defines.svh ====
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// ALUOP codes from decode
`define ALUOP_RTYPE   3'b000
`define ALUOP_ITYPE   3'b001
`define ALUOP_MEMADDR 3'b010
`define ALUOP_BRANCH  3'b011
`define ALUOP_LUI     3'b100
`define ALUOP_JALR    3'b101

// funct3 of the SYSTEM opcode, CSR forms
`define CSR_RW  3'b001
`define CSR_RS  3'b010
`define CSR_RC  3'b011
`define CSR_RWI 3'b101
`define CSR_RSI 3'b110
`define CSR_RCI 3'b111

`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_CYCLE    12'hC00
`define CSR_CYCLEH   12'hC80

`endif

// ==== source/exePkg.sv ====
package exePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [11:0] csrAddr_t;

    typedef logic [2:0] aluOpCode_t; // ALUOP from decode
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef enum logic [1:0] {
        fromDecode = 2'b00,
        fromMem    = 2'b01,
        fromWb     = 2'b10
    } fwdSel_t;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB, // lui
        aluBeq,
        aluBne,
        aluBlt,
        aluBge,
        aluBltu,
        aluBgeu
    } aluOp_t;

endpackage

// ==== source/csrBus.sv ====
`timescale 1ns/1ps

interface csrBus;
    import exePkg::*;

    csrAddr_t addr;
    logic     en;       // CSR instruction in execute
    funct3_t  funct3;
    word_t    srcValue; // rs1 value or zimm
    logic     srcZero;  // rs1 field is x0
    word_t    rdata;

    modport requester (
        output addr,
        output en,
        output funct3,
        output srcValue,
        output srcZero,
        input  rdata
    );

    modport responder (
        input  addr,
        input  en,
        input  funct3,
        input  srcValue,
        input  srcZero,
        output rdata
    );

endinterface

// ==== source/aluControl.sv ====
`timescale 1ns/1ps
`include "exe_defines.svh"

module aluControl (
    input  exePkg::aluOpCode_t aluOpCode,
    input  exePkg::funct3_t    funct3,
    input  exePkg::funct7_t    funct7,
    output exePkg::aluOp_t     aluCtrl
);
    import exePkg::*;

    // shared by R and I types, alt picks sub or sra
    function automatic aluOp_t arithOp(input funct3_t f3, input logic alt);
        aluOp_t op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    function automatic aluOp_t branchOp(input funct3_t f3);
        aluOp_t op;
        case (f3)
            3'b001:  op = aluBne;
            3'b100:  op = aluBlt;
            3'b101:  op = aluBge;
            3'b110:  op = aluBltu;
            3'b111:  op = aluBgeu;
            default: op = aluBeq; // 000 and reserved codes
        endcase
        return op;
    endfunction

    always_comb begin
        case (aluOpCode)
            `ALUOP_RTYPE:   aluCtrl = arithOp(funct3, funct7[5]);
            // immediate bit 10 is only an opcode bit for srai
            `ALUOP_ITYPE:   aluCtrl = arithOp(funct3, funct7[5] && funct3 == 3'b101);
            `ALUOP_MEMADDR: aluCtrl = aluAdd;
            `ALUOP_BRANCH:  aluCtrl = branchOp(funct3);
            `ALUOP_LUI:     aluCtrl = aluPassB;
            `ALUOP_JALR:    aluCtrl = aluAdd;
            default:        aluCtrl = aluAdd;
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  exePkg::word_t  opA,
    input  exePkg::word_t  opB,
    input  exePkg::aluOp_t aluCtrl,
    output exePkg::word_t  result,
    output logic           zeroFlag
);
    import exePkg::*;

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = opB[4:0];
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        case (aluCtrl)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'b0, lessSigned};
            aluSltu:  result = {31'b0, lessUnsigned};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $signed(opA) >>> shamt;
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            // compares give zero when the branch is taken
            aluBeq:   result = {31'b0, opA != opB};
            aluBne:   result = {31'b0, opA == opB};
            aluBlt:   result = {31'b0, !lessSigned};
            aluBge:   result = {31'b0, lessSigned};
            aluBltu:  result = {31'b0, !lessUnsigned};
            aluBgeu:  result = {31'b0, lessUnsigned};
            default:  result = '0;
        endcase
    end

    assign zeroFlag = (result == '0);

endmodule

// ==== source/csrUnit.sv ====
`timescale 1ns/1ps
`include "exe_defines.svh"

module csrUnit (
    input logic      clk,
    input logic      rst,
    csrBus.responder bus
);
    import exePkg::*;

    word_t       mtvec;
    word_t       mscratch;
    logic [63:0] cycleCnt;
    word_t       oldValue;
    word_t       newValue;
    logic        doWrite;

    always_comb begin
        case (bus.addr)
            `CSR_MTVEC:    oldValue = mtvec;
            `CSR_MSCRATCH: oldValue = mscratch;
            `CSR_CYCLE:    oldValue = cycleCnt[31:0];
            `CSR_CYCLEH:   oldValue = cycleCnt[63:32];
            default:       oldValue = '0; // unimplemented
        endcase
    end

    assign bus.rdata = oldValue;

    // read-modify-write value, set/clear skip the write for x0 or zimm 0
    always_comb begin
        case (bus.funct3)
            `CSR_RW, `CSR_RWI: begin
                newValue = bus.srcValue;
                doWrite  = bus.en;
            end
            `CSR_RS, `CSR_RSI: begin
                newValue = oldValue | bus.srcValue;
                doWrite  = bus.en && !bus.srcZero;
            end
            `CSR_RC, `CSR_RCI: begin
                newValue = oldValue & ~bus.srcValue;
                doWrite  = bus.en && !bus.srcZero;
            end
            default: begin
                newValue = oldValue;
                doWrite  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
            cycleCnt <= '0;
        end else begin
            cycleCnt <= cycleCnt + 64'd1; // free running
            if (doWrite && bus.addr == `CSR_MTVEC)
                mtvec <= newValue;
            if (doWrite && bus.addr == `CSR_MSCRATCH)
                mscratch <= newValue;
        end
    end

endmodule

// ==== source/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
    input  exePkg::regAddr_t rs1Addr,
    input  exePkg::regAddr_t rs2Addr,
    input  exePkg::regAddr_t memRdAddr,
    input  logic             memRegWrite,
    input  exePkg::regAddr_t wbRdAddr,
    input  logic             wbRegWrite,
    output exePkg::fwdSel_t  rs1Sel,
    output exePkg::fwdSel_t  rs2Sel
);
    import exePkg::*;

    // the younger result in memory wins over writeback
    function automatic fwdSel_t pickSource(input regAddr_t srcAddr);
        fwdSel_t sel;
        if (memRegWrite && memRdAddr != '0 && memRdAddr == srcAddr)
            sel = fromMem;
        else if (wbRegWrite && wbRdAddr != '0 && wbRdAddr == srcAddr)
            sel = fromWb;
        else
            sel = fromDecode;
        return sel;
    endfunction

    always_comb begin
        rs1Sel = pickSource(rs1Addr);
        rs2Sel = pickSource(rs2Addr);
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic               clk,
    input  logic               rst,
    input  exePkg::word_t      idPc,
    input  exePkg::word_t      idRs1Data,
    input  exePkg::word_t      idRs2Data,
    input  exePkg::word_t      idImm,
    input  exePkg::funct3_t    idFunct3,
    input  exePkg::funct7_t    idFunct7,
    input  exePkg::aluOpCode_t idAluOp,
    input  exePkg::regAddr_t   idRdAddr,
    input  exePkg::regAddr_t   idRs1Addr,
    input  logic               idPcToRegSrc,
    input  logic               idAluSrc,
    input  logic               idRdSrc,
    input  logic               idMemRead,
    input  logic               idMemWrite,
    input  logic               idMemToReg,
    input  logic               idRegWrite,
    input  exePkg::csrAddr_t   idCsrAddr,
    input  logic               idCsrEn,
    input  exePkg::word_t      memFwdData,
    input  exePkg::word_t      wbData,
    input  exePkg::fwdSel_t    rs1Sel,
    input  exePkg::fwdSel_t    rs2Sel,
    output exePkg::word_t      exePcToReg,
    output exePkg::word_t      exeAluOut,
    output exePkg::word_t      exeRs2Data,
    output exePkg::regAddr_t   exeRdAddr,
    output exePkg::funct3_t    exeFunct3,
    output logic               exeRdSrc,
    output logic               exeMemRead,
    output logic               exeMemWrite,
    output logic               exeMemToReg,
    output logic               exeRegWrite,
    output logic               zeroFlag,
    output exePkg::word_t      pcImm,
    output exePkg::word_t      pcJr
);
    import exePkg::*;

    word_t  rs1Value;
    word_t  rs2Value;
    word_t  opB;
    word_t  aluResult;
    word_t  pcPlus4;
    aluOp_t aluCtrl;

    csrBus csrIf ();

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t idData);
        word_t value;
        case (sel)
            fromMem: value = memFwdData;
            fromWb:  value = wbData;
            default: value = idData;
        endcase
        return value;
    endfunction

    assign rs1Value = fwdMux(rs1Sel, idRs1Data);
    assign rs2Value = fwdMux(rs2Sel, idRs2Data);
    assign opB      = idAluSrc ? rs2Value : idImm; // low picks the immediate

    assign pcImm   = idPc + idImm;
    assign pcPlus4 = idPc + 32'd4;
    assign pcJr    = {aluResult[31:1], 1'b0}; // jalr clears bit 0

    aluControl aluControl_i (
        .aluOpCode (idAluOp),
        .funct3    (idFunct3),
        .funct7    (idFunct7),
        .aluCtrl   (aluCtrl)
    );

    alu alu_i (
        .opA      (rs1Value),
        .opB      (opB),
        .aluCtrl  (aluCtrl),
        .result   (aluResult),
        .zeroFlag (zeroFlag)
    );

    // immediate CSR forms carry zimm in the rs1 field
    assign csrIf.addr     = idCsrAddr;
    assign csrIf.en       = idCsrEn;
    assign csrIf.funct3   = idFunct3;
    assign csrIf.srcValue = idFunct3[2] ? {27'b0, idRs1Addr} : rs1Value;
    assign csrIf.srcZero  = (idRs1Addr == '0);

    csrUnit csrUnit_i (
        .clk (clk),
        .rst (rst),
        .bus (csrIf.responder)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exePcToReg  <= '0;
            exeAluOut   <= '0;
            exeRs2Data  <= '0;
            exeRdAddr   <= '0;
            exeFunct3   <= '0;
            exeRdSrc    <= 1'b0;
            exeMemRead  <= 1'b0;
            exeMemWrite <= 1'b0;
            exeMemToReg <= 1'b0;
            exeRegWrite <= 1'b0;
        end else begin
            exePcToReg  <= idPcToRegSrc ? pcImm : pcPlus4; // auipc or link
            exeAluOut   <= idCsrEn ? csrIf.rdata : aluResult; // old CSR value
            exeRs2Data  <= rs2Value; // store data
            exeRdAddr   <= idRdAddr;
            exeFunct3   <= idFunct3;
            exeRdSrc    <= idRdSrc;
            exeMemRead  <= idMemRead;
            exeMemWrite <= idMemWrite;
            exeMemToReg <= idMemToReg;
            exeRegWrite <= idRegWrite;
        end
    end

endmodule

// ==== source/exeTop.sv ====
`timescale 1ns/1ps

module exeTop (
    input  logic               clk,
    input  logic               rst,
    input  exePkg::word_t      idPc,
    input  exePkg::word_t      idRs1Data,
    input  exePkg::word_t      idRs2Data,
    input  exePkg::word_t      idImm,
    input  exePkg::funct3_t    idFunct3,
    input  exePkg::funct7_t    idFunct7,
    input  exePkg::aluOpCode_t idAluOp,
    input  exePkg::regAddr_t   idRdAddr,
    input  exePkg::regAddr_t   idRs1Addr,
    input  exePkg::regAddr_t   idRs2Addr,
    input  logic               idPcToRegSrc,
    input  logic               idAluSrc,
    input  logic               idRdSrc,
    input  logic               idMemRead,
    input  logic               idMemWrite,
    input  logic               idMemToReg,
    input  logic               idRegWrite,
    input  exePkg::csrAddr_t   idCsrAddr,
    input  logic               idCsrEn,
    input  exePkg::word_t      memFwdData,
    input  exePkg::regAddr_t   memRdAddr,
    input  logic               memRegWrite,
    input  exePkg::word_t      wbData,
    input  exePkg::regAddr_t   wbRdAddr,
    input  logic               wbRegWrite,
    output exePkg::word_t      exePcToReg,
    output exePkg::word_t      exeAluOut,
    output exePkg::word_t      exeRs2Data,
    output exePkg::regAddr_t   exeRdAddr,
    output exePkg::funct3_t    exeFunct3,
    output logic               exeRdSrc,
    output logic               exeMemRead,
    output logic               exeMemWrite,
    output logic               exeMemToReg,
    output logic               exeRegWrite,
    output logic               zeroFlag,
    output exePkg::word_t      pcImm,
    output exePkg::word_t      pcJr
);
    import exePkg::*;

    fwdSel_t rs1Sel;
    fwdSel_t rs2Sel;

    forwardUnit forwardUnit_i (
        .rs1Addr     (idRs1Addr),
        .rs2Addr     (idRs2Addr),
        .memRdAddr   (memRdAddr),
        .memRegWrite (memRegWrite),
        .wbRdAddr    (wbRdAddr),
        .wbRegWrite  (wbRegWrite),
        .rs1Sel      (rs1Sel),
        .rs2Sel      (rs2Sel)
    );

    executeStage executeStage_i (
        .clk          (clk),
        .rst          (rst),
        .idPc         (idPc),
        .idRs1Data    (idRs1Data),
        .idRs2Data    (idRs2Data),
        .idImm        (idImm),
        .idFunct3     (idFunct3),
        .idFunct7     (idFunct7),
        .idAluOp      (idAluOp),
        .idRdAddr     (idRdAddr),
        .idRs1Addr    (idRs1Addr),
        .idPcToRegSrc (idPcToRegSrc),
        .idAluSrc     (idAluSrc),
        .idRdSrc      (idRdSrc),
        .idMemRead    (idMemRead),
        .idMemWrite   (idMemWrite),
        .idMemToReg   (idMemToReg),
        .idRegWrite   (idRegWrite),
        .idCsrAddr    (idCsrAddr),
        .idCsrEn      (idCsrEn),
        .memFwdData   (memFwdData),
        .wbData       (wbData),
        .rs1Sel       (rs1Sel),
        .rs2Sel       (rs2Sel),
        .exePcToReg   (exePcToReg),
        .exeAluOut    (exeAluOut),
        .exeRs2Data   (exeRs2Data),
        .exeRdAddr    (exeRdAddr),
        .exeFunct3    (exeFunct3),
        .exeRdSrc     (exeRdSrc),
        .exeMemRead   (exeMemRead),
        .exeMemWrite  (exeMemWrite),
        .exeMemToReg  (exeMemToReg),
        .exeRegWrite  (exeRegWrite),
        .zeroFlag     (zeroFlag),
        .pcImm        (pcImm),
        .pcJr         (pcJr)
    );

endmodule

// ==== testbench/exeTop_chk.sv ====
`timescale 1ns/1ps

module exeTop_chk (
    input logic             clk,
    input logic             rst,
    input exePkg::regAddr_t idRdAddr,
    input exePkg::funct3_t  idFunct3,
    input logic             idRdSrc,
    input logic             idMemRead,
    input logic             idMemWrite,
    input logic             idMemToReg,
    input logic             idRegWrite,
    input exePkg::word_t    exePcToReg,
    input exePkg::word_t    exeAluOut,
    input exePkg::word_t    exeRs2Data,
    input exePkg::regAddr_t exeRdAddr,
    input exePkg::funct3_t  exeFunct3,
    input logic             exeRdSrc,
    input logic             exeMemRead,
    input logic             exeMemWrite,
    input logic             exeMemToReg,
    input logic             exeRegWrite
);
    import exePkg::*;

    int unsigned failCount = 0; // polled by the testbench
    logic [4:0]  ctrlIn;
    logic [4:0]  ctrlOut;
    logic        exeIdle;

    assign ctrlIn  = {idRdSrc, idMemRead, idMemWrite, idMemToReg, idRegWrite};
    assign ctrlOut = {exeRdSrc, exeMemRead, exeMemWrite, exeMemToReg, exeRegWrite};
    assign exeIdle = exePcToReg == '0 && exeAluOut == '0 && exeRs2Data == '0
                     && exeRdAddr == '0 && exeFunct3 == '0 && ctrlOut == '0;

    resetClears: assert property (@(posedge clk) $past(rst) |-> exeIdle)
        else begin
            failCount++;
            $error("exe outputs not zero after a reset cycle");
        end

    fieldsFollow: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> exeRdAddr == $past(idRdAddr) && exeFunct3 == $past(idFunct3))
        else begin
            failCount++;
            $error("exeRdAddr or exeFunct3 not taken from the previous cycle");
        end

    ctrlFollows: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> ctrlOut == $past(ctrlIn))
        else begin
            failCount++;
            $error("memory stage controls not taken from the previous cycle");
        end

endmodule

bind exeTop exeTop_chk exeTop_chk_i (.*);

// ==== testbench/exeTop_tb.sv ====
`timescale 1ns/1ps
`include "exe_defines.svh"

module exeTop_tb;
    import exePkg::*;

    logic       clk;
    logic       rst;
    word_t      idPc;
    word_t      idRs1Data;
    word_t      idRs2Data;
    word_t      idImm;
    funct3_t    idFunct3;
    funct7_t    idFunct7;
    aluOpCode_t idAluOp;
    regAddr_t   idRdAddr;
    regAddr_t   idRs1Addr;
    regAddr_t   idRs2Addr;
    logic       idPcToRegSrc;
    logic       idAluSrc;
    logic       idRdSrc;
    logic       idMemRead;
    logic       idMemWrite;
    logic       idMemToReg;
    logic       idRegWrite;
    csrAddr_t   idCsrAddr;
    logic       idCsrEn;
    word_t      memFwdData;
    regAddr_t   memRdAddr;
    logic       memRegWrite;
    word_t      wbData;
    regAddr_t   wbRdAddr;
    logic       wbRegWrite;
    word_t      exePcToReg;
    word_t      exeAluOut;
    word_t      exeRs2Data;
    regAddr_t   exeRdAddr;
    funct3_t    exeFunct3;
    logic       exeRdSrc;
    logic       exeMemRead;
    logic       exeMemWrite;
    logic       exeMemToReg;
    logic       exeRegWrite;
    logic       zeroFlag;
    word_t      pcImm;
    word_t      pcJr;

    word_t      mtvecRef; // expected CSR contents
    word_t      mscratchRef;

    exeTop exeTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportError(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "first error reached");
    endtask

    always @(negedge clk) begin
        if (exeTop_i.exeTop_chk_i.failCount != 0)
            reportError("an assertion in the bound checker failed");
    end

    // memory stage before writeback and never x0
    function automatic word_t fwdValue(input regAddr_t src, input word_t idData);
        if (memRegWrite && memRdAddr != 5'd0 && memRdAddr == src)
            return memFwdData;
        if (wbRegWrite && wbRdAddr != 5'd0 && wbRdAddr == src)
            return wbData;
        return idData;
    endfunction

    function automatic word_t expectAlu(input aluOpCode_t code, input funct3_t f3,
                                        input funct7_t f7, input word_t a, input word_t b);
        logic  alt;
        word_t r;
        if (code == `ALUOP_LUI)
            return b;
        if (code != `ALUOP_RTYPE && code != `ALUOP_ITYPE)
            return a + b; // address forms
        alt = (code == `ALUOP_RTYPE) ? f7[5] : (f7[5] && f3 == 3'b101);
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t linkValue();
        return idPcToRegSrc ? idPc + idImm : idPc + 32'd4;
    endfunction

    task automatic randomizeInputs();
        idPc         = $urandom() & 32'hFFFF_FFFC;
        idRs1Data    = $urandom();
        idRs2Data    = $urandom();
        idImm        = $urandom();
        idFunct3     = funct3_t'($urandom_range(7, 0));
        idFunct7     = 7'h00;
        idAluOp      = `ALUOP_MEMADDR;
        idAluSrc     = 1'($urandom_range(1, 0));
        idRdAddr     = regAddr_t'($urandom_range(31, 0));
        idRs1Addr    = regAddr_t'($urandom_range(3, 0)); // narrow range gives frequent matches
        idRs2Addr    = regAddr_t'($urandom_range(3, 0));
        idPcToRegSrc = 1'($urandom_range(1, 0));
        {idRdSrc, idMemRead, idMemWrite, idMemToReg, idRegWrite} = 5'($urandom());
        idCsrEn      = 1'b0;
        idCsrAddr    = csrAddr_t'($urandom());
        memFwdData   = $urandom();
        memRdAddr    = regAddr_t'($urandom_range(3, 0));
        memRegWrite  = 1'($urandom_range(1, 0));
        wbData       = $urandom();
        wbRdAddr     = regAddr_t'($urandom_range(3, 0));
        wbRegWrite   = 1'($urandom_range(1, 0));
    endtask

    task automatic checkNextCycle(input word_t expAlu, input logic checkAlu,
                                  input word_t expRs2, input word_t expLink);
        @(posedge clk);
        #2;
        if (checkAlu) begin
            assert (exeAluOut == expAlu)
                else reportError($sformatf("exeAluOut is %h, expected %h",
                                           exeAluOut, expAlu));
        end
        assert (exeRs2Data == expRs2)
            else reportError($sformatf("exeRs2Data is %h, expected %h",
                                       exeRs2Data, expRs2));
        assert (exePcToReg == expLink)
            else reportError($sformatf("exePcToReg is %h, expected %h",
                                       exePcToReg, expLink));
    endtask

    task automatic runAluTests(input int count);
        int    pick;
        word_t rs1;
        word_t rs2;
        for (int i = 0; i < count; i++) begin
            randomizeInputs();
            pick = $urandom_range(3, 0);
            case (pick)
                0:       idAluOp = `ALUOP_RTYPE;
                1:       idAluOp = `ALUOP_ITYPE;
                2:       idAluOp = `ALUOP_LUI;
                default: idAluOp = `ALUOP_MEMADDR;
            endcase
            idFunct7 = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
            idAluSrc = (idAluOp == `ALUOP_RTYPE);
            rs1 = fwdValue(idRs1Addr, idRs1Data);
            rs2 = fwdValue(idRs2Addr, idRs2Data);
            checkNextCycle(expectAlu(idAluOp, idFunct3, idFunct7, rs1, idAluSrc ? rs2 : idImm),
                           1'b1, rs2, linkValue());
        end
    endtask

    task automatic runBranchTests(input int count);
        funct3_t brF3 [6];
        word_t   rs1;
        word_t   rs2;
        logic    taken;
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < count; i++) begin
            randomizeInputs();
            if ($urandom_range(3, 0) == 0) begin
                memRegWrite = 1'b0;
                wbRegWrite  = 1'b0;
                idRs2Data   = idRs1Data; // equal operands
            end
            rs1 = fwdValue(idRs1Addr, idRs1Data);
            rs2 = fwdValue(idRs2Addr, idRs2Data);
            if ($urandom_range(1, 0) == 0) begin
                idAluOp  = `ALUOP_BRANCH;
                idFunct3 = brF3[$urandom_range(5, 0)];
                idAluSrc = 1'b1;
                taken    = branchTaken(idFunct3, rs1, rs2);
                #1;
                assert (zeroFlag == taken)
                    else reportError($sformatf("zeroFlag is %b for funct3 %b, expected %b",
                                               zeroFlag, idFunct3, taken));
                assert (pcImm == idPc + idImm)
                    else reportError($sformatf("pcImm is %h, expected %h",
                                               pcImm, idPc + idImm));
                checkNextCycle({31'b0, !taken}, 1'b1, rs2, linkValue());
            end else begin
                idAluOp  = `ALUOP_JALR;
                idAluSrc = 1'b0;
                #1;
                assert (pcJr == ((rs1 + idImm) & 32'hFFFF_FFFE))
                    else reportError($sformatf("pcJr is %h for rs1 %h and imm %h",
                                               pcJr, rs1, idImm));
                checkNextCycle(rs1 + idImm, 1'b1, rs2, linkValue());
            end
        end
    endtask

    // one CSR instruction with its old value checked a cycle later
    task automatic csrStep(input funct3_t f3, input csrAddr_t addr, input logic zeroSrc,
                           output word_t seen);
        word_t src;
        word_t old;
        word_t upd;
        logic  write;
        randomizeInputs();
        idCsrEn   = 1'b1;
        idFunct3  = f3;
        idCsrAddr = addr;
        idRs1Addr = zeroSrc ? 5'd0 : regAddr_t'($urandom_range(31, 1));
        src = f3[2] ? {27'b0, idRs1Addr} : fwdValue(idRs1Addr, idRs1Data);
        case (addr)
            `CSR_MTVEC:    old = mtvecRef;
            `CSR_MSCRATCH: old = mscratchRef;
            default:       old = '0; // cycleh stays zero in a short run
        endcase
        case (f3)
            `CSR_RW, `CSR_RWI: begin
                upd   = src;
                write = 1'b1;
            end
            `CSR_RS, `CSR_RSI: begin
                upd   = old | src;
                write = !zeroSrc;
            end
            default: begin
                upd   = old & ~src;
                write = !zeroSrc;
            end
        endcase
        checkNextCycle(old, addr != `CSR_CYCLE, fwdValue(idRs2Addr, idRs2Data), linkValue());
        seen = exeAluOut;
        if (write && addr == `CSR_MTVEC)
            mtvecRef = upd;
        if (write && addr == `CSR_MSCRATCH)
            mscratchRef = upd;
    endtask

    task automatic runCsrTests();
        funct3_t  forms [6];
        csrAddr_t targets [2];
        word_t    seen;
        word_t    prev;
        int       tries;
        forms   = '{`CSR_RW, `CSR_RS, `CSR_RC, `CSR_RWI, `CSR_RSI, `CSR_RCI};
        targets = '{`CSR_MTVEC, `CSR_MSCRATCH};
        for (int round = 0; round < 3; round++) begin
            for (int t = 0; t < 2; t++) begin
                for (int f = 0; f < 6; f++) begin
                    csrStep(forms[f], targets[t], 1'b0, seen);
                    csrStep(`CSR_RS, targets[t], 1'b1, seen); // read back
                    csrStep(forms[f], targets[t], 1'b1, seen);
                    csrStep(`CSR_RS, targets[t], 1'b1, seen);
                end
            end
        end

        // cycle ignores writes and keeps counting
        csrStep(`CSR_RW, `CSR_CYCLE, 1'b0, prev);
        tries = 0;
        seen  = prev;
        while (seen == prev) begin
            if (tries == 8) begin
                $display("cycle counter did not advance within 8 reads at %0t ns", $time);
                $display("Simulation FAILED");
                $fatal(1, "cycle counter stuck");
            end
            csrStep(`CSR_RS, `CSR_CYCLE, 1'b1, seen);
            tries++;
        end
        assert (seen == prev + 32'd1)
            else reportError($sformatf("cycle read %h after %h", seen, prev));
        for (int k = 0; k < 4; k++) begin
            prev = seen;
            csrStep(`CSR_RS, `CSR_CYCLE, 1'b1, seen);
            assert (seen == prev + 32'd1)
                else reportError($sformatf("cycle read %h after %h", seen, prev));
        end
        csrStep(`CSR_RS, `CSR_CYCLEH, 1'b1, seen);
        csrStep(`CSR_RW, 12'h7C0, 1'b0, seen); // unimplemented address
        csrStep(`CSR_RS, 12'h7C0, 1'b1, seen);
    endtask

    initial begin
        void'($urandom(32'h195fb58c));
        rst         = 1'b1;
        mtvecRef    = '0;
        mscratchRef = '0;
        randomizeInputs();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        runAluTests(400);
        runBranchTests(300);
        runCsrTests();
        @(posedge clk);
        #2;
        if (exeTop_i.exeTop_chk_i.failCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            reportError("an assertion in the bound checker failed");
        end
    end

endmodule

// ==== list.f ====
+incdir+include
source/exePkg.sv
source/csrBus.sv
source/aluControl.sv
source/alu.sv
source/csrUnit.sv
source/forwardUnit.sv
source/executeStage.sv
source/exeTop.sv
testbench/exeTop_chk.sv
testbench/exeTop_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module exeTop_tb

# a raised error limit lets the testbench see bound assertion failures
simOut=$(./obj_dir/VexeTop_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
